// ==== src.f ====
+incdir+hw
+incdir+verification
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/instr_predecoder.sv
hw/control_unit.sv
hw/imm_extender.sv
hw/register_file.sv
hw/decode_stage.sv
verification/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_decode_stage \
    --Mdir obj_dir -o sim_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_decode > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// ==== verification/tb_decode_vectors.svh ====
`ifndef TB_DECODE_VECTORS_SVH
`define TB_DECODE_VECTORS_SVH

// Each row gives the word, PC, writeback mode and register, expected control, bubble and halt
// Control bits are {agu_src_pc, jump, branch, reg_wr_en, mem_wr_en, wb_src_alu, jmp_trg_reg}
localparam int NUM_VEC = 23;

task automatic fill_table();
    vecs[0]  = '{mk_r(5'd0, 5'd1, 5'd3, 5'd4, FN_SLL), 32'h0040_0000, WB_PRE, 5'd1,
        mk_ctrl(SRC_A_RT, 1'b1, DST_RD, ALU_SLL, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[1]  = '{mk_r(5'd0, 5'd2, 5'd3, 5'd3, FN_SRA), 32'h0040_0004, WB_PRE, 5'd2,
        mk_ctrl(SRC_A_RT, 1'b1, DST_RD, ALU_SRA, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[2]  = '{mk_r(5'd1, 5'd2, 5'd4, 5'd0, FN_SLLV), 32'h0040_0008, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_SLL, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[3]  = '{mk_r(5'd1, 5'd2, 5'd5, 5'd0, FN_ADDU), 32'h0040_000C, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[4]  = '{mk_r(5'd2, 5'd1, 5'd6, 5'd0, FN_SLT), 32'h0040_0010, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_SLT, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[5]  = '{mk_r(5'd1, 5'd0, 5'd0, 5'd0, FN_JR), 32'h0040_0014, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_PASS, AGU_REG, 7'b0100001, EXT_SIGN), 2'b00};
    vecs[6]  = '{mk_r(5'd2, 5'd0, 5'd31, 5'd0, FN_JALR), 32'h0040_0018, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_PC4, 1'b0, DST_RD, ALU_PASS, AGU_REG, 7'b0101011, EXT_SIGN), 2'b00};
    vecs[7]  = '{mk_i(OP_ADDI, 5'd1, 5'd5, 16'hFFF0), 32'h0040_001C, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_IMM, 1'b0, DST_RT, ALU_SADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[8]  = '{mk_i(OP_ADDI, 5'd2, 5'd5, 16'h0123), 32'h0040_0020, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_IMM, 1'b0, DST_RT, ALU_SADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[9]  = '{mk_i(OP_ORI, 5'd1, 5'd6, 16'h8001), 32'h0040_0024, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_IMM, 1'b0, DST_RT, ALU_OR, AGU_REG, 7'b0001010, EXT_ZERO_UPPER), 2'b00};
    vecs[10] = '{mk_i(OP_LUI, 5'd0, 5'd7, 16'h8765), 32'h0040_0028, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_IMM, 1'b0, DST_RT, ALU_PASS, AGU_REG, 7'b0001010, EXT_ZERO_LOWER), 2'b00};
    vecs[11] = '{mk_r(5'd0, 5'd0, 5'd8, 5'd0, FN_ADDU), 32'h0040_002C, WB_PRE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[12] = '{mk_r(5'd6, 5'd1, 5'd7, 5'd0, FN_ADDU), 32'h0040_0030, WB_SAME, 5'd6,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[13] = '{mk_i(OP_LW, 5'd1, 5'd8, 16'h0004), 32'h0040_0034, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RT, ALU_PASS, AGU_MEM, 7'b0001000, EXT_SIGN), 2'b00};
    vecs[14] = '{mk_r(5'd8, 5'd1, 5'd9, 5'd0, FN_ADDU), 32'h0040_0038, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0000010, EXT_SIGN), 2'b10};
    vecs[15] = '{mk_r(5'd8, 5'd1, 5'd9, 5'd0, FN_ADDU), 32'h0040_0038, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[16] = '{mk_i(OP_LW, 5'd2, 5'd10, 16'h0008), 32'h0040_003C, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RT, ALU_PASS, AGU_MEM, 7'b0001000, EXT_SIGN), 2'b00};
    vecs[17] = '{mk_r(5'd2, 5'd3, 5'd11, 5'd0, FN_ADDU), 32'h0040_0040, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0001010, EXT_SIGN), 2'b00};
    vecs[18] = '{mk_i(OP_SW, 5'd1, 5'd2, 16'h000C), 32'h0040_0044, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RT, ALU_PASS, AGU_MEM, 7'b0000110, EXT_SIGN), 2'b00};
    vecs[19] = '{mk_i(OP_BEQ, 5'd1, 5'd2, 16'hFFFC), 32'h0040_0048, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RT, ALU_CMP, AGU_BRANCH, 7'b1010000, EXT_SIGN), 2'b00};
    vecs[20] = '{mk_j(OP_J, 26'h0000040), 32'h0040_004C, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_PC4, 1'b0, DST_RA, ALU_PASS, AGU_JUMP, 7'b1100010, EXT_SIGN), 2'b00};
    vecs[21] = '{mk_j(OP_JAL, 26'h0000100), 32'h0040_0050, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_PC4, 1'b0, DST_RA, ALU_PASS, AGU_JUMP, 7'b1101010, EXT_SIGN), 2'b00};
    vecs[22] = '{mk_i(OP_HALT, 5'd0, 5'd0, 16'h0021), 32'h0040_0054, WB_NONE, 5'd0,
        mk_ctrl(SRC_A_RT, 1'b0, DST_RD, ALU_ADD, AGU_REG, 7'b0000010, EXT_SIGN), 2'b01};
endtask

`endif

// ==== verification/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module tb_decode_stage;
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam logic [1:0] WB_NONE = 2'd0;
    localparam logic [1:0] WB_PRE  = 2'd1;             // Write one cycle before the request
    localparam logic [1:0] WB_SAME = 2'd2;             // Write at the accepting edge, read bypasses

    typedef struct {
        instr_t     instr;
        logic [31:0] pc;
        logic [1:0] wb_mode;
        logic [4:0] wb_addr;
        ctrl_word_t ctrl;
        logic [1:0] bh;                                // Expected {bubble, halt}
    } vec_t;

    logic                    clk;
    logic                    arst_n;
    logic                    req;
    instr_t                  instr;
    logic [`MIPS_DATA_W-1:0] pc;
    wb_t                     wb;
    logic                    ack;
    id_out_t                 dut_out;
    vec_t                    vecs [23];
    logic [31:0]             shadow [32];          // Expected register contents
    logic [31:0]             lfsr_state;
    int                      errors;
    int                      cur_vec;

    decode_stage decode_stage_inst (
        .i_clk    (clk),
        .i_arst_n (arst_n),
        .i_req    (req),
        .i_instr  (instr),
        .i_pc     (pc),
        .i_wb     (wb),
        .o_ack    (ack),
        .o_out    (dut_out)
    );

    function automatic instr_t mk_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                    logic [4:0] sh, funct_e fn);
        return instr_t'({OP_RTYPE, rs, rt, rd, sh, fn});
    endfunction

    function automatic instr_t mk_i(opcode_e op, logic [4:0] rs, logic [4:0] rt, logic [15:0] imm);
        return instr_t'({op, rs, rt, imm});
    endfunction

    function automatic instr_t mk_j(opcode_e op, logic [25:0] index);
        return instr_t'({op, index});
    endfunction

    function automatic ctrl_word_t mk_ctrl(alu_src_a_e a, logic b, alu_dst_e d, alu_op_e op,
                                           agu_op_e agu, logic [6:0] bits, ext_mode_e e);
        return '{a, b, d, op, bits[6], agu, bits[5], bits[4], bits[3], bits[2], bits[1],
                 bits[0], e};
    endfunction

    `include "tb_decode_vectors.svh"

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit of the word
    function automatic logic [31:0] rand_word();
        logic [31:0] word;
        logic        fb;
        for (int i = 0; i < 32; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            word       = {word[30:0], fb};
        end
        return word;
    endfunction

    // The 16-bit immediate extended the way each mode defines it
    function automatic logic [31:0] extend(logic [15:0] imm, ext_mode_e mode);
        case (mode)
            EXT_SIGN:       return {{16{imm[15]}}, imm};
            EXT_ZERO_LOWER: return {imm, 16'h0000};
            default:        return {16'h0000, imm};
        endcase
    endfunction

    task automatic check_ctrl(ctrl_word_t got, ctrl_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error: vector %0d o_out.ctrl got %h expected %h", cur_vec, got, exp);
        end
    endtask

    task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: vector %0d %s got %h expected %h", cur_vec, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error: vector %0d %s got %h expected %h", cur_vec, name, got, exp);
        end
    endtask

    // Four-phase transfer of one table row, with an optional writeback before or during it
    task automatic apply_vector(int idx);
        vec_t        v;
        logic [31:0] wdata;
        int          cycles;
        v       = vecs[idx];
        cur_vec = idx;
        if (v.wb_mode != WB_NONE) begin
            wdata = rand_word();
            wb    = '{en: 1'b1, addr: v.wb_addr, data: wdata};
            if (v.wb_mode == WB_PRE) begin
                @(negedge clk);                        // Write lands on the edge in between
                wb = '0;
            end
            if (v.wb_addr != 5'd0) shadow[v.wb_addr] = wdata;
        end
        instr  = v.instr;
        pc     = v.pc;
        req    = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < 5);
        wb = '0;
        if (!ack) begin
            errors++;
            $display("Vector %0d: the stage never acknowledged the request", idx);
        end else begin
            check_word("ack_rise_cycles", cycles, 1);
            check_ctrl(dut_out.ctrl, v.ctrl);
            check_word("o_out.rs_data", dut_out.rs_data, shadow[v.instr.rs]);
            check_word("o_out.rt_data", dut_out.rt_data, shadow[v.instr.rt]);
            check_word("o_out.imm_ext", dut_out.imm_ext,
                       extend({v.instr.rd, v.instr.shamt, v.instr.funct}, v.ctrl.ext_mode));
            check_word("o_out.pc_plus4", dut_out.pc_plus4, v.pc + 32'd4);
            check_word("o_out.shamt", 32'(dut_out.shamt), 32'(v.instr.shamt));
            check_word("o_out.rd", 32'(dut_out.rd), 32'(v.instr.rd));
            check_word("o_out.rt", 32'(dut_out.rt), 32'(v.instr.rt));
            check_flag("o_out.bubble", dut_out.bubble, v.bh[1]);
            check_flag("o_out.halt", dut_out.halt, v.bh[0]);
        end
        req    = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < 5);
        check_word("ack_fall_cycles", cycles, 1);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                        // 100 ns period
    end

    // Every row needs well under 10 cycles, reset adds a few more
    initial begin
        #(100 * (NUM_VEC * 10 + 10));
        $display("Watchdog expired before the table was finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        arst_n     = 1'b0;
        req        = 1'b0;
        instr      = '0;
        pc         = '0;
        wb         = '0;
        errors     = 0;
        cur_vec    = -1;
        lfsr_state = 32'd78093;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        fill_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_flag("o_ack", ack, 1'b0);                // Idle after reset
        check_ctrl(dut_out.ctrl, '0);
        check_flag("o_out.bubble", dut_out.bubble, 1'b0);
        for (int i = 0; i < NUM_VEC; i++) apply_vector(i);
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module decode_stage (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_req,
    input  mips_isa_pkg::instr_t    i_instr,
    input  logic [`MIPS_DATA_W-1:0] i_pc,
    input  mips_ctrl_pkg::wb_t      i_wb,
    output logic                    o_ack,
    output mips_ctrl_pkg::id_out_t  o_out
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    typedef enum logic {
        ST_IDLE,                                      // Waiting for a request
        ST_ACK                                        // Word captured, waiting for req to drop
    } hs_state_e;

    hs_state_e               state;
    logic                    accept;                  // Request seen while idle
    decode_flags_t           flags;
    logic                    halt;
    logic [5:0]              cu_funct;
    ctrl_word_t              ctrl;
    logic [`MIPS_DATA_W-1:0] imm_ext;
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;
    logic                    ld_valid;                // Last accepted word was a load
    logic [`MIPS_REG_AW-1:0] ld_rt;                   // Destination of that load
    logic                    hazard;

    instr_predecoder instr_predecoder_inst (
        .i_opcode (i_instr.opcode),
        .i_funct  (i_instr.funct),
        .o_flags  (flags),
        .o_halt   (halt)
    );

    // I-type words reuse the function input with the opcode low bits
    assign cu_funct = flags.immediate ? {3'b000, i_instr.opcode[2:0]} : i_instr.funct;

    control_unit control_unit_inst (
        .i_flags  (flags),
        .i_funct  (cu_funct),
        .i_hazard (hazard),
        .i_halt   (halt),
        .o_ctrl   (ctrl)
    );

    imm_extender imm_extender_inst (
        .i_imm     ({i_instr.rd, i_instr.shamt, i_instr.funct}),
        .i_mode    (ctrl.ext_mode),
        .o_imm_ext (imm_ext)
    );

    register_file register_file_inst (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_wb      (i_wb),
        .i_rs_addr (i_instr.rs),
        .i_rt_addr (i_instr.rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    assign accept = (state == ST_IDLE) && i_req;
    assign o_ack  = (state == ST_ACK);
    assign hazard = ld_valid && ld_rt != '0 && (ld_rt == i_instr.rs || ld_rt == i_instr.rt);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state    <= ST_IDLE;
            ld_valid <= 1'b0;
            ld_rt    <= '0;
            o_out    <= '0;                           // No write enables and no bubble
        end else begin
            if (accept) begin
                state    <= ST_ACK;
                ld_valid <= !hazard && i_instr.opcode == OP_LW; // Bubble clears the tracking
                ld_rt    <= i_instr.rt;
                o_out    <= '{ctrl: ctrl, rs_data: rs_data, rt_data: rt_data,
                              imm_ext: imm_ext, pc_plus4: i_pc + `MIPS_DATA_W'(4),
                              shamt: i_instr.shamt, rd: i_instr.rd, rt: i_instr.rt,
                              bubble: hazard, halt: halt};
            end else if (state == ST_ACK && !i_req) begin
                state <= ST_IDLE;                     // Four-phase return to zero
            end
        end
    end

    // Acknowledge follows a request sampled on the previous edge
    assert property (@(posedge i_clk) disable iff (!i_arst_n) $rose(o_ack) |-> $past(i_req));

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module register_file (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  mips_ctrl_pkg::wb_t      i_wb,
    input  logic [`MIPS_REG_AW-1:0] i_rs_addr,
    input  logic [`MIPS_REG_AW-1:0] i_rt_addr,
    output logic [`MIPS_DATA_W-1:0] o_rs_data,
    output logic [`MIPS_DATA_W-1:0] o_rt_data
);
    logic [`MIPS_DATA_W-1:0] regs [`MIPS_NUM_REGS];

    // Same-cycle writeback wins over the stored word, register zero never bypasses
    function automatic logic [`MIPS_DATA_W-1:0] read_port(input logic [`MIPS_REG_AW-1:0] addr);
        if (i_wb.en && i_wb.addr == addr && addr != '0) begin
            return i_wb.data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;                        // All registers start at zero
            end
        end else if (i_wb.en && i_wb.addr != '0) begin
            regs[i_wb.addr] <= i_wb.data;             // Register zero is hardwired
        end
    end

    assign o_rs_data = read_port(i_rs_addr);
    assign o_rt_data = read_port(i_rt_addr);

    // Holds across any history of writebacks aimed at register zero
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rs_addr == '0) |-> (o_rs_data == '0));
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rt_addr == '0) |-> (o_rt_data == '0));

endmodule

`default_nettype wire

// ==== hw/imm_extender.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module imm_extender (
    input  logic [15:0]                  i_imm,
    input  mips_ctrl_pkg::ext_mode_e     i_mode,
    output logic [`MIPS_DATA_W-1:0]      o_imm_ext
);
    import mips_ctrl_pkg::*;

    always_comb begin
        case (i_mode)
            EXT_SIGN:       o_imm_ext = {{(`MIPS_DATA_W-16){i_imm[15]}}, i_imm}; // Arithmetic
            EXT_ZERO_LOWER: o_imm_ext = {i_imm, {(`MIPS_DATA_W-16){1'b0}}};      // LUI
            default:        o_imm_ext = {{(`MIPS_DATA_W-16){1'b0}}, i_imm};      // Logic ops
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  mips_ctrl_pkg::decode_flags_t i_flags,
    input  logic [5:0]                   i_funct,    // I-type carries the opcode low bits
    input  logic                         i_hazard,
    input  logic                         i_halt,
    output mips_ctrl_pkg::ctrl_word_t    o_ctrl
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [5:0] flag_key;                             // Flags without mem_type, in fixed order

    assign flag_key = {i_flags.pc_modify, i_flags.link_ret, i_flags.addr_type,
                       i_flags.immediate, i_flags.mem_op};

    always_comb begin
        o_ctrl           = '0;                        // No writes, no jump, no branch
        o_ctrl.alu_src_a = SRC_A_RT;
        o_ctrl.alu_dst   = DST_RD;
        o_ctrl.alu_op    = ALU_PASS;
        o_ctrl.agu_op    = AGU_REG;
        o_ctrl.ext_mode  = EXT_SIGN;
        casez (flag_key)
            6'b000000: begin                          // R-type arithmetic, logic and shifts
                o_ctrl.reg_wr_en  = 1'b1;
                o_ctrl.wb_src_alu = 1'b1;
                case (funct_e'(i_funct))
                    FN_SLL: begin
                        o_ctrl.alu_src_b = 1'b1;
                        o_ctrl.alu_op    = ALU_SLL;
                    end
                    FN_SRL: begin
                        o_ctrl.alu_src_b = 1'b1;
                        o_ctrl.alu_op    = ALU_SRL;
                    end
                    FN_SRA: begin
                        o_ctrl.alu_src_b = 1'b1;
                        o_ctrl.alu_op    = ALU_SRA;
                    end
                    FN_SLLV: o_ctrl.alu_op = ALU_SLL;
                    FN_SRLV: o_ctrl.alu_op = ALU_SRL;
                    FN_SRAV: o_ctrl.alu_op = ALU_SRA;
                    FN_ADDU: o_ctrl.alu_op = ALU_ADD;
                    FN_SUBU: o_ctrl.alu_op = ALU_SUB;
                    FN_AND:  o_ctrl.alu_op = ALU_AND;
                    FN_OR:   o_ctrl.alu_op = ALU_OR;
                    FN_XOR:  o_ctrl.alu_op = ALU_XOR;
                    FN_NOR:  o_ctrl.alu_op = ALU_NOR;
                    FN_SLT:  o_ctrl.alu_op = ALU_SLT;
                    default: o_ctrl.reg_wr_en = 1'b0; // Unknown function writes nothing
                endcase
            end
            6'b1?0000: begin                          // JR and JALR
                o_ctrl.jump        = 1'b1;
                o_ctrl.jmp_trg_reg = 1'b1;            // Target is rs
                if (i_flags.link_ret) begin
                    o_ctrl.alu_src_a  = SRC_A_PC4;    // Return address goes to rd
                    o_ctrl.reg_wr_en  = 1'b1;
                    o_ctrl.wb_src_alu = 1'b1;
                end
            end
            6'b000011: begin                          // LW and SW
                o_ctrl.alu_dst    = DST_RT;
                o_ctrl.agu_op     = AGU_MEM;
                o_ctrl.reg_wr_en  = !i_flags.mem_type;
                o_ctrl.mem_wr_en  = i_flags.mem_type;
                o_ctrl.wb_src_alu = i_flags.mem_type; // Loads write back memory data
            end
            6'b000010: begin                          // Arithmetic and logic with immediate
                o_ctrl.alu_src_a  = SRC_A_IMM;
                o_ctrl.alu_dst    = DST_RT;
                o_ctrl.reg_wr_en  = 1'b1;
                o_ctrl.wb_src_alu = 1'b1;
                case (opcode_e'({3'b001, i_funct[2:0]}))
                    OP_ADDI: o_ctrl.alu_op = ALU_SADD;
                    OP_SLTI: o_ctrl.alu_op = ALU_SLT;
                    OP_ANDI: begin
                        o_ctrl.alu_op   = ALU_AND;
                        o_ctrl.ext_mode = EXT_ZERO_UPPER;
                    end
                    OP_ORI: begin
                        o_ctrl.alu_op   = ALU_OR;
                        o_ctrl.ext_mode = EXT_ZERO_UPPER;
                    end
                    OP_XORI: begin
                        o_ctrl.alu_op   = ALU_XOR;
                        o_ctrl.ext_mode = EXT_ZERO_UPPER;
                    end
                    OP_LUI: o_ctrl.ext_mode = EXT_ZERO_LOWER; // PASS moves it to rt
                    default: o_ctrl.reg_wr_en = 1'b0;
                endcase
            end
            6'b101010: begin                          // BEQ compares rs and rt in the ALU
                o_ctrl.alu_dst    = DST_RT;
                o_ctrl.alu_op     = ALU_CMP;
                o_ctrl.agu_src_pc = 1'b1;
                o_ctrl.agu_op     = AGU_BRANCH;
                o_ctrl.branch     = 1'b1;
            end
            6'b1?0100: begin                          // J and JAL
                o_ctrl.alu_src_a  = SRC_A_PC4;
                o_ctrl.alu_dst    = DST_RA;
                o_ctrl.agu_src_pc = 1'b1;
                o_ctrl.agu_op     = AGU_JUMP;
                o_ctrl.jump       = 1'b1;
                o_ctrl.reg_wr_en  = i_flags.link_ret; // Only JAL saves the return address
                o_ctrl.wb_src_alu = 1'b1;
            end
            default: ;                                // Reserved patterns keep the no-write defaults
        endcase
        if (i_hazard || i_halt) begin
            o_ctrl.reg_wr_en = 1'b0;                  // Stalled or halted words change no state
            o_ctrl.mem_wr_en = 1'b0;
        end
    end

    // Execute would take two different next-PC sources at once
    always_comb begin
        assert (!(o_ctrl.jump && o_ctrl.branch))
            else $error("jump and branch both set, flags %b", flag_key);
    end

endmodule

`default_nettype wire

// ==== hw/instr_predecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_predecoder (
    input  mips_isa_pkg::opcode_e        i_opcode,
    input  mips_isa_pkg::funct_e         i_funct,
    output mips_ctrl_pkg::decode_flags_t o_flags,
    output logic                         o_halt
);
    import mips_isa_pkg::*;

    always_comb begin
        o_flags = '0;                                 // All clear is an ordinary R-type
        o_halt  = 1'b0;
        case (i_opcode)
            OP_RTYPE: begin
                if (i_funct == FN_JR || i_funct == FN_JALR) begin
                    o_flags.pc_modify = 1'b1;         // Register jump, addr_type stays 00
                    o_flags.link_ret  = (i_funct == FN_JALR);
                end
            end
            OP_J, OP_JAL: begin
                o_flags.pc_modify = 1'b1;
                o_flags.link_ret  = (i_opcode == OP_JAL); // Only JAL writes $ra
                o_flags.addr_type = 2'b01;            // Pseudo-direct target
            end
            OP_BEQ: begin
                o_flags.pc_modify = 1'b1;
                o_flags.addr_type = 2'b10;            // PC relative target
                o_flags.immediate = 1'b1;
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                o_flags.immediate = 1'b1;             // ALU works on the extended immediate
            end
            OP_LW, OP_SW: begin
                o_flags.immediate = 1'b1;
                o_flags.mem_op    = 1'b1;
                o_flags.mem_type  = (i_opcode == OP_SW);
            end
            OP_HALT: begin
                o_halt = 1'b1;                        // Control unit kills the writes
            end
            default: begin
                o_flags.addr_type = 2'b11;            // Reserved pattern decodes as a no-write op
            end
        endcase
    end

    // A store or load marker must always come with a memory operation
    always_comb begin
        assert (!o_flags.mem_type || o_flags.mem_op)
            else $error("mem_type set without mem_op for opcode %0h", i_opcode);
    end

endmodule

`default_nettype wire

// ==== hw/mips_ctrl_pkg.sv ====
`default_nettype none

`include "mips_defs.svh"

package mips_ctrl_pkg;

    // ALU operation codes as the execute stage expects them
    typedef enum logic [3:0] {
        ALU_SRL  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SRA  = 4'b0010,
        ALU_PASS = 4'b0011,             // Forwards source A, used for links, LUI and stores
        ALU_ADD  = 4'b0100,
        ALU_SUB  = 4'b0101,
        ALU_AND  = 4'b0110,
        ALU_OR   = 4'b0111,
        ALU_XOR  = 4'b1000,
        ALU_NOR  = 4'b1001,
        ALU_SLT  = 4'b1010,
        ALU_CMP  = 4'b1011,             // Equality compare for branches
        ALU_SADD = 4'b1100              // Signed add with overflow check
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_SIGN       = 2'b00,         // Bit 15 fills the upper half
        EXT_ZERO_UPPER = 2'b01,         // Zeros fill the upper half
        EXT_ZERO_LOWER = 2'b10          // Immediate moves to the upper half
    } ext_mode_e;

    typedef enum logic [1:0] {
        SRC_A_PC4 = 2'b00,
        SRC_A_RT  = 2'b01,
        SRC_A_IMM = 2'b11
    } alu_src_a_e;

    typedef enum logic [1:0] {
        DST_RT = 2'b00,
        DST_RD = 2'b01,
        DST_RA = 2'b11                  // Register 31
    } alu_dst_e;

    typedef enum logic [2:0] {
        AGU_REG    = 3'b000,            // Target is the content of rs
        AGU_MEM    = 3'b001,            // Base plus offset for loads and stores
        AGU_BRANCH = 3'b010,            // PC plus shifted offset
        AGU_JUMP   = 3'b011             // PC upper bits with the 26-bit index
    } agu_op_e;

    typedef struct packed {
        logic       pc_modify;          // Jump or branch
        logic       link_ret;           // Saves the return address
        logic [1:0] addr_type;          // 00 register, 01 pseudo-direct, 10 PC relative
        logic       immediate;          // I-type encoding
        logic       mem_op;
        logic       mem_type;           // Store when set, load when clear
    } decode_flags_t;

    typedef struct packed {
        alu_src_a_e alu_src_a;
        logic       alu_src_b;          // Set when shamt replaces rs as operand B
        alu_dst_e   alu_dst;
        alu_op_e    alu_op;
        logic       agu_src_pc;         // AGU base is the PC rather than rs
        agu_op_e    agu_op;
        logic       jump;
        logic       branch;
        logic       reg_wr_en;
        logic       mem_wr_en;
        logic       wb_src_alu;         // Writeback takes the ALU result, else memory data
        logic       jmp_trg_reg;        // Jump target comes from a register
        ext_mode_e  ext_mode;
    } ctrl_word_t;

    typedef struct packed {
        logic                    en;
        logic [`MIPS_REG_AW-1:0] addr;
        logic [`MIPS_DATA_W-1:0] data;
    } wb_t;

    typedef struct packed {
        ctrl_word_t              ctrl;
        logic [`MIPS_DATA_W-1:0] rs_data;
        logic [`MIPS_DATA_W-1:0] rt_data;
        logic [`MIPS_DATA_W-1:0] imm_ext;
        logic [`MIPS_DATA_W-1:0] pc_plus4;
        logic [4:0]              shamt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [`MIPS_REG_AW-1:0] rt;
        logic                    bubble; // Load-use stall, fetch presents the word again
        logic                    halt;
    } id_out_t;

endpackage

`default_nettype wire

// ==== hw/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // Primary opcode field, bits 31:26 of the instruction word
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,           // Function code selects the operation
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_ADDI  = 6'b001000,           // Low three bits double as the I-type function code
        OP_SLTI  = 6'b001010,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_XORI  = 6'b001110,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_HALT  = 6'b111111            // Stops the pipeline
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,            // Shift amount comes from shamt
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,            // Shift amount comes from a register
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

    // R-type view of the word, the I-type immediate is {rd, shamt, funct}
    typedef struct packed {
        opcode_e    opcode;             // Bits 31:26
        logic [4:0] rs;                 // Bits 25:21
        logic [4:0] rt;                 // Bits 20:16
        logic [4:0] rd;                 // Bits 15:11
        logic [4:0] shamt;              // Bits 10:6
        funct_e     funct;              // Bits 5:0
    } instr_t;

endpackage

`default_nettype wire

// ==== hw/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Word width of the datapath, register contents and PC
`define MIPS_DATA_W 32

// Register file addressing
`define MIPS_REG_AW 5
`define MIPS_NUM_REGS 32

`endif
